/* hw/decode_pkg.sv */
// RV32I base set only; the M extension, FENCE and system opcodes have no entries and decode as illegal
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes kept from the base set
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ALU funct3 codes, shared by OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} instr_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // LUI result is op2
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_NONE, // Bubble
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_UPPER // LUI and AUIPC
    } op_kind_e;

    typedef enum logic [1:0] {FWD_NONE, FWD_EXEC, FWD_WB} fwd_sel_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word seen through each encoding
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // All zeros is the bubble
    typedef struct packed {
        op_kind_e   kind;
        alu_op_e    alu_op;
        logic       op1_pc;    // Operand 1 is the PC
        logic       op2_imm;   // Operand 2 is the immediate
        logic [2:0] funct3;    // Branch condition or memory size
        logic       writes_rd;
        logic [2:0] spare;     // Held at zero
    } micro_op_t;

    typedef struct packed {
        logic lt;
        logic ltu;
        logic eq;
    } cmp_flags_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
        logic                  en;
    } wb_port_t;

    typedef struct packed {
        micro_op_t             uop;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        cmp_flags_t            cmp;
        logic [1:0]            fmt_jb;  // Bit 1 J format, bit 0 B format
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc_plus;
    } exec_bundle_t;

endpackage

/* hw/instr_decoder.sv */
// Purely combinational; illegal encodings give a bubble uop and FMT_R, store data is not carried in the uop
`timescale 1ns/1ns

module instr_decoder import decode_pkg::*; (
    input  instr_u     instr_i,
    output micro_op_t  uop_o,
    output instr_fmt_e fmt_o,
    output logic       illegal_o
);

    micro_op_t  uop_raw;
    instr_fmt_e fmt_raw;
    logic       legal;
    logic [2:0] f3;
    logic [6:0] f7;

    assign f3 = instr_i.r.funct3;
    assign f7 = instr_i.r.funct7;

    // Same funct3 map for register and immediate ALU ops
    function automatic alu_op_e alu_from_f3(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    always_comb begin
        uop_raw = '0;
        fmt_raw = FMT_R;
        legal   = 1'b1;
        case (instr_i.r.opcode)
            OP_LUI: begin
                uop_raw.kind      = KIND_UPPER;
                uop_raw.alu_op    = ALU_PASS_B;
                uop_raw.op2_imm   = 1'b1;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_U;
            end
            OP_AUIPC: begin
                uop_raw.kind      = KIND_UPPER;
                uop_raw.alu_op    = ALU_ADD;
                uop_raw.op1_pc    = 1'b1; // PC + upper immediate
                uop_raw.op2_imm   = 1'b1;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_U;
            end
            OP_JAL: begin
                uop_raw.kind      = KIND_JAL;
                uop_raw.alu_op    = ALU_ADD;
                uop_raw.op1_pc    = 1'b1; // Target is PC + offset
                uop_raw.op2_imm   = 1'b1;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_J;
            end
            OP_JALR: begin
                uop_raw.kind      = KIND_JALR;
                uop_raw.alu_op    = ALU_ADD; // Target is rs1 + offset
                uop_raw.op2_imm   = 1'b1;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_I;
                legal             = (f3 == 3'b000);
            end
            OP_BRANCH: begin
                uop_raw.kind   = KIND_BRANCH;
                uop_raw.alu_op = ALU_SUB;
                uop_raw.funct3 = f3;
                fmt_raw        = FMT_B;
                legal          = (f3[2:1] != 2'b01); // No 010 or 011 condition
            end
            OP_LOAD: begin
                uop_raw.kind      = KIND_LOAD;
                uop_raw.alu_op    = ALU_ADD;
                uop_raw.op2_imm   = 1'b1;
                uop_raw.funct3    = f3;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_I;
                legal             = (f3 != 3'b011) && (f3[2:1] != 2'b11); // LB LH LW LBU LHU
            end
            OP_STORE: begin
                uop_raw.kind    = KIND_STORE;
                uop_raw.alu_op  = ALU_ADD;
                uop_raw.op2_imm = 1'b1;
                uop_raw.funct3  = f3;
                fmt_raw         = FMT_S;
                legal           = !f3[2] && (f3 != 3'b011); // SB SH SW
            end
            OP_IMM: begin
                uop_raw.kind      = KIND_ALU;
                uop_raw.alu_op    = alu_from_f3(f3, (f3 == F3_SR) && (f7 == F7_ALT));
                uop_raw.op2_imm   = 1'b1;
                uop_raw.funct3    = f3;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_I;
                // Upper immediate bits are funct7 only for the shifts
                if (f3 == F3_SLL) begin
                    legal = (f7 == F7_ZERO);
                end else if (f3 == F3_SR) begin
                    legal = (f7 == F7_ZERO) || (f7 == F7_ALT);
                end
            end
            OP_REG: begin
                uop_raw.kind      = KIND_ALU;
                uop_raw.alu_op    = alu_from_f3(f3, f7 == F7_ALT);
                uop_raw.funct3    = f3;
                uop_raw.writes_rd = 1'b1;
                fmt_raw           = FMT_R;
                legal = (f7 == F7_ZERO) ||
                        ((f7 == F7_ALT) && ((f3 == F3_ADD_SUB) || (f3 == F3_SR)));
            end
            default: legal = 1'b0; // Includes FENCE and SYSTEM
        endcase
    end

    assign uop_o     = legal ? uop_raw : '0;
    assign fmt_o     = legal ? fmt_raw : FMT_R;
    assign illegal_o = !legal;

endmodule

/* hw/imm_gen.sv */
// Combinational; all immediates sign extend from instruction bit 31 and FMT_R or unused codes give zero
`timescale 1ns/1ns

module imm_gen import decode_pkg::*; (
    input  instr_u            instr_i,
    input  instr_fmt_e        fmt_i,
    output logic [XLEN-1:0]   imm_o
);

    always_comb begin
        case (fmt_i)
            FMT_I: imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
            FMT_S: imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
            FMT_B: begin
                imm_o = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                         instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0}; // Halfword aligned
            end
            FMT_U: imm_o = {instr_i.u.imm_31_12, 12'b0};
            FMT_J: begin
                imm_o = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                         instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
            end
            default: imm_o = '0; // No immediate in R format
        endcase
    end

endmodule

/* hw/reg_file.sv */
// Reads are combinational and see the old value during a same-cycle write, so writeback must be forwarded
`timescale 1ns/1ns

module reg_file import decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  wb_port_t              wb_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int k = 1; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.en && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data; // Writes to x0 dropped
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* hw/operand_select.sv */
// Forwarding is applied before the PC or immediate choice, so an immediate operand 2 is never overridden
`timescale 1ns/1ns

module operand_select import decode_pkg::*; (
    input  micro_op_t       uop_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] exec_fwd_i,
    input  logic [XLEN-1:0] wb_data_i,
    input  fwd_sel_e        fwd1_sel_i,
    input  fwd_sel_e        fwd2_sel_i,
    output logic [XLEN-1:0] op1_o,
    output logic [XLEN-1:0] op2_o,
    output cmp_flags_t      cmp_o
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;

    function automatic logic [XLEN-1:0] pick_fwd(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] exec_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EXEC: return exec_val;
            FWD_WB:   return wb_val;
            default:  return reg_val; // FWD_NONE and the unused code
        endcase
    endfunction

    assign rs1_fwd = pick_fwd(fwd1_sel_i, rs1_data_i, exec_fwd_i, wb_data_i);
    assign rs2_fwd = pick_fwd(fwd2_sel_i, rs2_data_i, exec_fwd_i, wb_data_i);

    assign op1_o = uop_i.op1_pc  ? pc_i  : rs1_fwd;
    assign op2_o = uop_i.op2_imm ? imm_i : rs2_fwd;

    // Relations for branches and set-less-than
    assign cmp_o.lt  = $signed(rs1_fwd) < $signed(op2_o);
    assign cmp_o.ltu = rs1_fwd < op2_o;
    assign cmp_o.eq  = rs1_fwd == op2_o;

endmodule

/* hw/decode_stage.sv */
// Decode and register read; exec_o lags instr_i by one edge, flush beats stall, and rs/illegal are combinational
`timescale 1ns/1ns

module decode_stage import decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  instr_u                instr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       pc_plus_i,
    input  wb_port_t              wb_i,
    input  logic [XLEN-1:0]       exec_fwd_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  fwd_sel_e              fwd1_sel_i,
    input  fwd_sel_e              fwd2_sel_i,
    output exec_bundle_t          exec_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic                  illegal_o
);

    micro_op_t       uop;
    instr_fmt_e      fmt;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    cmp_flags_t      cmp;
    exec_bundle_t    exec_next;

    // Hazard unit compares these against younger destinations
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;

    instr_decoder u_decoder (
        .instr_i   (instr_i),
        .uop_o     (uop),
        .fmt_o     (fmt),
        .illegal_o (illegal_o)
    );

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (instr_i.r.rs1),
        .rs2_addr_i (instr_i.r.rs2),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    operand_select u_operand_select (
        .uop_i      (uop),
        .pc_i       (pc_i),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exec_fwd_i (exec_fwd_i),
        .wb_data_i  (wb_i.data),
        .fwd1_sel_i (fwd1_sel_i),
        .fwd2_sel_i (fwd2_sel_i),
        .op1_o      (op1),
        .op2_o      (op2),
        .cmp_o      (cmp)
    );

    always_comb begin
        exec_next.uop     = uop;
        exec_next.op1     = op1;
        exec_next.op2     = op2;
        exec_next.cmp     = cmp;
        exec_next.fmt_jb  = {fmt == FMT_J, fmt == FMT_B}; // Execute picks the jump target form
        exec_next.rd      = instr_i.r.rd;
        exec_next.pc_plus = pc_plus_i; // Link value for JAL and JALR
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            exec_o <= '0; // Bubble with writes_rd low
        end else if (!stall_i) begin
            exec_o <= exec_next;
        end
    end

endmodule

/* tb/tb_decode_stage.sv */
// Directed tests of the decode stage; exec_o is sampled on the falling edge after the update edge
`timescale 1ns/1ns

module tb_decode_stage import decode_pkg::*; ();

    localparam int PERIOD        = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int TEST_CYCLES   = 100; // Sum over all test tasks, rounded up
    localparam int MARGIN_CYCLES = 50;

    logic         clk_i;
    logic         reset_i;
    instr_u       instr_i;
    logic [31:0]  pc_i;
    logic [31:0]  pc_plus_i;
    wb_port_t     wb_i;
    logic [31:0]  exec_fwd_i;
    logic         stall_i;
    logic         flush_i;
    fwd_sel_e     fwd1_sel_i;
    fwd_sel_e     fwd2_sel_i;
    exec_bundle_t exec_o;
    logic [4:0]   rs1_addr_o;
    logic [4:0]   rs2_addr_o;
    logic         illegal_o;

    logic [31:0]  lfsr_state;
    logic [31:0]  model_regs [0:31]; // Expected register contents

    decode_stage uut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .pc_plus_i  (pc_plus_i),
        .wb_i       (wb_i),
        .exec_fwd_i (exec_fwd_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .fwd1_sel_i (fwd1_sel_i),
        .fwd2_sel_i (fwd2_sel_i),
        .exec_o     (exec_o),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .illegal_o  (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]}; // One step per bit
        end
        return v;
    endfunction

    // Standard RV32 immediate formulas on the raw word
    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
            OP_STORE:        return {{20{w[31]}}, w[31:25], w[11:7]};
            OP_BRANCH:       return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OP_LUI, OP_AUIPC: return {w[31:12], 12'b0};
            OP_JAL:          return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:         return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_i = '{addr: addr, data: data, en: 1'b1};
        step();
        wb_i.en = 1'b0;
        if (addr != 5'd0) model_regs[addr] = data; // x0 stays zero
    endtask

    task automatic test_reset_flush();
        check_value("exec_o after reset", exec_o, '0);
        instr_i = {12'h123, 5'd0, 3'b000, 5'd5, OP_IMM}; // ADDI x5, x0, 0x123
        step();
        check_value("op2 of ADDI", exec_o.op2, 32'h123);
        check_value("writes_rd of ADDI", exec_o.uop.writes_rd, 1'b1);
        flush_i = 1'b1;
        stall_i = 1'b1; // Flush must win
        step();
        check_value("exec_o after flush", exec_o, '0);
        flush_i = 1'b0;
        stall_i = 1'b0;
    endtask

    task automatic rtype_case(input logic [2:0] f3, input logic [6:0] f7,
                              input alu_op_e exp_alu, input logic use_x0);
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        r = rand_bits(15);
        rs1 = use_x0 ? 5'd0 : r[4:0];
        rs2 = use_x0 ? 5'd0 : r[9:5];
        rd  = r[14:10];
        instr_i = {f7, rs2, rs1, f3, rd, OP_REG};
        step();
        check_value("illegal_o", illegal_o, 1'b0);
        check_value("rs1_addr_o", rs1_addr_o, rs1);
        check_value("rs2_addr_o", rs2_addr_o, rs2);
        check_value("op1", exec_o.op1, model_regs[rs1]);
        check_value("op2", exec_o.op2, model_regs[rs2]);
        check_value("alu_op", exec_o.uop.alu_op, exp_alu);
        check_value("rd", exec_o.rd, rd);
    endtask

    task automatic test_regs_rtype();
        for (int k = 0; k < 12; k++) begin
            write_reg(rand_bits(5), rand_bits(32));
        end
        write_reg(5'd0, 32'hdead_beef);
        rtype_case(3'b000, 7'h00, ALU_ADD, 1'b0);
        rtype_case(3'b000, 7'h20, ALU_SUB, 1'b0);
        rtype_case(3'b001, 7'h00, ALU_SLL, 1'b0);
        rtype_case(3'b010, 7'h00, ALU_SLT, 1'b0);
        rtype_case(3'b011, 7'h00, ALU_SLTU, 1'b0);
        rtype_case(3'b100, 7'h00, ALU_XOR, 1'b0);
        rtype_case(3'b101, 7'h00, ALU_SRL, 1'b0);
        rtype_case(3'b101, 7'h20, ALU_SRA, 1'b0);
        rtype_case(3'b110, 7'h00, ALU_OR, 1'b0);
        rtype_case(3'b111, 7'h00, ALU_AND, 1'b0);
        rtype_case(3'b000, 7'h00, ALU_ADD, 1'b1); // x0 reads zero
    endtask

    task automatic imm_form(input logic [6:0] opc, input logic [2:0] f3, input logic set_f3);
        logic [31:0] w;
        logic [31:0] imm;
        for (int k = 0; k < 4; k++) begin
            w = rand_bits(32);
            w[6:0] = opc;
            if (set_f3) w[14:12] = f3;
            imm = expected_imm(w);
            pc_i = rand_bits(30) << 2;
            pc_plus_i = pc_i + 32'd4;
            instr_i = w;
            step();
            if (opc == OP_BRANCH) begin
                check_value("branch immediate", uut.imm, imm);
            end else begin
                check_value("op2 immediate", exec_o.op2, imm);
            end
            check_value("fmt_jb", exec_o.fmt_jb, {opc == OP_JAL, opc == OP_BRANCH});
            check_value("pc_plus", exec_o.pc_plus, pc_plus_i);
            if (opc == OP_JAL || opc == OP_AUIPC) check_value("op1 pc", exec_o.op1, pc_i);
        end
    endtask

    task automatic test_immediates();
        imm_form(OP_IMM, 3'b000, 1'b1);
        imm_form(OP_STORE, 3'b010, 1'b1);
        imm_form(OP_BRANCH, 3'b000, 1'b1);
        imm_form(OP_LUI, 3'b000, 1'b0);
        imm_form(OP_AUIPC, 3'b000, 1'b0);
        imm_form(OP_JAL, 3'b000, 1'b0);
    endtask

    task automatic test_forwarding();
        exec_fwd_i = rand_bits(32);
        wb_i.data  = rand_bits(32);
        instr_i    = {7'h00, 5'd3, 5'd4, 3'b000, 5'd1, OP_REG};
        fwd1_sel_i = FWD_EXEC;
        fwd2_sel_i = FWD_WB;
        step();
        check_value("op1 from execute", exec_o.op1, exec_fwd_i);
        check_value("op2 from writeback", exec_o.op2, wb_i.data);
        fwd1_sel_i = FWD_WB;
        fwd2_sel_i = FWD_EXEC;
        step();
        check_value("op1 from writeback", exec_o.op1, wb_i.data);
        check_value("op2 from execute", exec_o.op2, exec_fwd_i);
        instr_i = {12'hf81, 5'd4, 3'b000, 5'd1, OP_IMM}; // Immediate must beat forwarding
        step();
        check_value("op2 immediate under forwarding", exec_o.op2, 32'hffff_ff81);
        check_value("op1 forwarded for ADDI", exec_o.op1, wb_i.data);
        fwd1_sel_i = FWD_NONE;
        fwd2_sel_i = FWD_NONE;
    endtask

    task automatic test_compare();
        logic [31:0] a;
        logic [31:0] b;
        instr_i    = {7'h00, 5'd6, 5'd7, 3'b000, 5'd0, OP_BRANCH}; // BEQ
        fwd1_sel_i = FWD_EXEC;
        fwd2_sel_i = FWD_WB;
        for (int k = 0; k < 16; k++) begin
            a = rand_bits(32);
            b = (k % 4 == 0) ? a : rand_bits(32);
            exec_fwd_i = a;
            wb_i.data  = b;
            step();
            check_value("kind", exec_o.uop.kind, KIND_BRANCH);
            check_value("cmp.lt", exec_o.cmp.lt, $signed(a) < $signed(b));
            check_value("cmp.ltu", exec_o.cmp.ltu, a < b);
            check_value("cmp.eq", exec_o.cmp.eq, a == b);
        end
        fwd1_sel_i = FWD_NONE;
        fwd2_sel_i = FWD_NONE;
    endtask

    task automatic illegal_case(input logic [31:0] w);
        instr_i = w;
        step();
        check_value("illegal_o", illegal_o, 1'b1);
        check_value("uop of illegal", exec_o.uop, '0);
    endtask

    task automatic test_stall_illegal();
        exec_bundle_t held;
        instr_i = {12'h055, 5'd2, 3'b000, 5'd9, OP_IMM};
        step();
        held = exec_o;
        stall_i = 1'b1;
        for (int k = 0; k < 3; k++) begin
            instr_i = {7'h00, 5'd1, 5'd2, 3'b100, 5'd12, OP_REG};
            pc_i = rand_bits(32);
            pc_plus_i = pc_i + 32'd4;
            step();
            check_value("exec_o under stall", exec_o, held);
        end
        stall_i = 1'b0;
        step();
        check_value("rd after stall", exec_o.rd, 5'd12);
        check_value("pc_plus after stall", exec_o.pc_plus, pc_plus_i);
        illegal_case({25'h0, 7'b1111111});
        illegal_case({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG}); // MUL
        illegal_case(32'h0000_0073); // ECALL
    endtask

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("Timeout: the tests did not finish within the expected number of cycles");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        lfsr_state = 32'h8787;
        reset_i    = 1'b1;
        instr_i    = '0;
        pc_i       = '0;
        pc_plus_i  = 32'h4;
        wb_i       = '0;
        exec_fwd_i = '0;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        fwd1_sel_i = FWD_NONE;
        fwd2_sel_i = FWD_NONE;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        test_reset_flush();
        test_regs_rtype();
        test_immediates();
        test_forwarding();
        test_compare();
        test_stall_illegal();
        $display("Verification passed");
        $finish;
    end

endmodule

/* list.f */
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/operand_select.sv
hw/decode_stage.sv
tb/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hw/decode_pkg.sv
      - hw/instr_decoder.sv
      - hw/imm_gen.sv
      - hw/reg_file.sv
      - hw/operand_select.sv
      - hw/decode_stage.sv
  - target: test
    files:
      - tb/tb_decode_stage.sv
